// ==== src/bfly_pkg.sv ====
package bfly_pkg;

    // Network size
    localparam int NUM_CORES      = 8;
    localparam int NUM_STAGES     = $clog2(NUM_CORES);
    localparam int NUM_BANKS      = NUM_CORES / 2;
    localparam int NUM_FWD_LAYERS = NUM_STAGES - 1;
    localparam int NUM_LAYERS     = NUM_FWD_LAYERS + NUM_STAGES;
    localparam int TOTAL_SWITCHES = NUM_LAYERS * NUM_CORES / 2;

    // Field widths
    localparam int CORE_ID_W    = NUM_STAGES;
    localparam int MOD_ID_W     = NUM_STAGES;
    localparam int LOCAL_ADDR_W = 4;
    localparam int PRIO_W       = 2;
    localparam int DATA_W       = 16;
    localparam int COLL_COUNT_W = $clog2(TOTAL_SWITCHES + 1);

    typedef logic [CORE_ID_W-1:0]    core_id_t;
    // Bank number in the upper bits, bank port in bit 0
    typedef logic [MOD_ID_W-1:0]     mod_id_t;
    typedef logic [LOCAL_ADDR_W-1:0] local_addr_t;
    typedef logic [PRIO_W-1:0]       prio_t;
    typedef logic [DATA_W-1:0]       data_t;
    typedef logic [COLL_COUNT_W-1:0] coll_count_t;

    // Request packet, MSB to LSB: rw, core_id, mod_id, local_addr, prio, data
    localparam int REQ_DATA_LSB    = 0;
    localparam int REQ_PRIO_LSB    = REQ_DATA_LSB + DATA_W;
    localparam int REQ_ADDR_LSB    = REQ_PRIO_LSB + PRIO_W;
    localparam int REQ_MOD_ID_LSB  = REQ_ADDR_LSB + LOCAL_ADDR_W;
    localparam int REQ_CORE_ID_LSB = REQ_MOD_ID_LSB + MOD_ID_W;
    localparam int REQ_RW_BIT      = REQ_CORE_ID_LSB + CORE_ID_W;
    localparam int REQ_PKT_W       = REQ_RW_BIT + 1;

    // Response packet, MSB to LSB: rw, core_id, data
    localparam int RSP_DATA_LSB    = 0;
    localparam int RSP_CORE_ID_LSB = RSP_DATA_LSB + DATA_W;
    localparam int RSP_RW_BIT      = RSP_CORE_ID_LSB + CORE_ID_W;
    localparam int RSP_PKT_W       = RSP_RW_BIT + 1;

    typedef logic [REQ_PKT_W-1:0] req_pkt_t;
    typedef logic [RSP_PKT_W-1:0] rsp_pkt_t;

    // Bank contents at power-up
    localparam data_t INIT_WORD = '1;

endpackage

// ==== src/bfly_switch.sv ====
`timescale 1ns/1ns

module bfly_switch #(
    parameter int PKT_W     = bfly_pkg::REQ_PKT_W,
    parameter int ROUTE_LSB = bfly_pkg::REQ_MOD_ID_LSB,
    parameter int STAGE_IDX = 0
) (
    input  logic                           clk,
    input  logic                           i_reset,
    input  logic [PKT_W-1:0]               i_pkt_a,
    input  logic [PKT_W-1:0]               i_pkt_b,
    input  logic                           i_valid_a,
    input  logic                           i_valid_b,
    output logic [PKT_W-1:0]               o_pkt_0,
    output logic [PKT_W-1:0]               o_pkt_1,
    output logic                           o_valid_0,
    output logic                           o_valid_1,
    output logic [bfly_pkg::NUM_CORES-1:0] o_dropped_cores,
    output logic                           o_collision
);
    import bfly_pkg::*;

    // Each layer resolves one bit of the routing field, MSB first
    localparam int ROUTE_BIT = ROUTE_LSB + NUM_STAGES - 1 - STAGE_IDX;

    prio_t                prio_a;
    prio_t                prio_b;
    core_id_t             core_a;
    core_id_t             core_b;
    logic                 sel_a;
    logic                 sel_b;
    logic                 collide;
    logic                 b_wins;
    logic                 go_a;
    logic                 go_b;
    logic                 valid_0_d;
    logic                 valid_1_d;
    logic [PKT_W-1:0]     pkt_0_d;
    logic [PKT_W-1:0]     pkt_1_d;
    logic [NUM_CORES-1:0] drop_d;

    if (PKT_W == REQ_PKT_W) begin : g_req_fields
        assign prio_a = i_pkt_a[REQ_PRIO_LSB +: PRIO_W];
        assign prio_b = i_pkt_b[REQ_PRIO_LSB +: PRIO_W];
        assign core_a = i_pkt_a[REQ_CORE_ID_LSB +: CORE_ID_W];
        assign core_b = i_pkt_b[REQ_CORE_ID_LSB +: CORE_ID_W];
    end else begin : g_rsp_fields
        // Responses have no priority field so the upper input always wins
        assign prio_a = '0;
        assign prio_b = '0;
        assign core_a = i_pkt_a[RSP_CORE_ID_LSB +: CORE_ID_W];
        assign core_b = i_pkt_b[RSP_CORE_ID_LSB +: CORE_ID_W];
    end

    assign sel_a   = i_pkt_a[ROUTE_BIT];
    assign sel_b   = i_pkt_b[ROUTE_BIT];
    assign collide = i_valid_a && i_valid_b && (sel_a == sel_b);
    // Strictly greater, so a tie leaves the upper input in place
    assign b_wins  = prio_b > prio_a;
    assign go_a    = i_valid_a && !(collide && b_wins);
    assign go_b    = i_valid_b && !(collide && !b_wins);

    always_comb begin
        valid_0_d = (go_a && !sel_a) || (go_b && !sel_b);
        valid_1_d = (go_a && sel_a) || (go_b && sel_b);
        pkt_0_d   = (go_a && !sel_a) ? i_pkt_a : i_pkt_b;
        pkt_1_d   = (go_a && sel_a) ? i_pkt_a : i_pkt_b;
        drop_d    = '0;
        if (collide) begin
            drop_d[b_wins ? core_a : core_b] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid_0       <= 1'b0;
            o_valid_1       <= 1'b0;
            o_dropped_cores <= '0;
            o_collision     <= 1'b0;
        end else begin
            o_valid_0       <= valid_0_d;
            o_valid_1       <= valid_1_d;
            o_dropped_cores <= drop_d;
            o_collision     <= collide;
        end
    end

    always_ff @(posedge clk) begin
        o_pkt_0 <= pkt_0_d;
        o_pkt_1 <= pkt_1_d;
    end

    // A switch never creates traffic on its own
    a_no_spurious_out: assert property (
        @(posedge clk) disable iff (i_reset)
        (o_valid_0 || o_valid_1) |-> $past(i_valid_a || i_valid_b)
    );

endmodule

// ==== src/bfly_stage.sv ====
`timescale 1ns/1ns

module bfly_stage #(
    parameter int PKT_W       = bfly_pkg::REQ_PKT_W,
    parameter int ROUTE_LSB   = bfly_pkg::REQ_MOD_ID_LSB,
    parameter int STAGE_IDX   = 0,
    parameter bit OUT_PERMUTE = 1'b1
) (
    input  logic                                      clk,
    input  logic                                      i_reset,
    input  logic [bfly_pkg::NUM_CORES-1:0][PKT_W-1:0] i_pkts,
    input  logic [bfly_pkg::NUM_CORES-1:0]            i_valid,
    output logic [bfly_pkg::NUM_CORES-1:0][PKT_W-1:0] o_pkts,
    output logic [bfly_pkg::NUM_CORES-1:0]            o_valid,
    output logic [bfly_pkg::NUM_CORES/2-1:0]          o_collisions,
    output logic [bfly_pkg::NUM_CORES-1:0]            o_dropped_cores
);
    import bfly_pkg::*;

    localparam int NUM_SW = NUM_CORES / 2;
    // Distance between the two inputs of a switch halves every layer
    localparam int HALF   = 1 << (NUM_STAGES - 1 - STAGE_IDX);

    logic [NUM_CORES-1:0] sw_drops [NUM_SW];

    for (genvar j = 0; j < NUM_SW; j++) begin : g_sw
        localparam int BLOCK = j / HALF;
        localparam int POS   = j % HALF;
        localparam int IDX_A = BLOCK * 2 * HALF + POS;
        localparam int IDX_B = IDX_A + HALF;
        // Permuted outputs keep the pair positions that the next layer indexes
        // Straight-through outputs put switch j on ports 2j and 2j+1
        localparam int OUT_0 = OUT_PERMUTE ? IDX_A : 2 * j;
        localparam int OUT_1 = OUT_PERMUTE ? IDX_B : 2 * j + 1;

        bfly_switch #(
            .PKT_W     (PKT_W),
            .ROUTE_LSB (ROUTE_LSB),
            .STAGE_IDX (STAGE_IDX)
        ) u_switch (
            .clk             (clk),
            .i_reset         (i_reset),
            .i_pkt_a         (i_pkts[IDX_A]),
            .i_pkt_b         (i_pkts[IDX_B]),
            .i_valid_a       (i_valid[IDX_A]),
            .i_valid_b       (i_valid[IDX_B]),
            .o_pkt_0         (o_pkts[OUT_0]),
            .o_pkt_1         (o_pkts[OUT_1]),
            .o_valid_0       (o_valid[OUT_0]),
            .o_valid_1       (o_valid[OUT_1]),
            .o_dropped_cores (sw_drops[j]),
            .o_collision     (o_collisions[j])
        );
    end

    // Merge the per-switch drop vectors of this layer
    always_comb begin
        o_dropped_cores = '0;
        for (int j = 0; j < NUM_SW; j++) begin
            o_dropped_cores = o_dropped_cores | sw_drops[j];
        end
    end

    // Packets in one layer belong to distinct cores so each collision drops its own core
    a_drops_match_collisions: assert property (
        @(posedge clk) disable iff (i_reset)
        $countones(o_dropped_cores) == $countones(o_collisions)
    );

endmodule

// ==== src/bfly_mem_bank.sv ====
`timescale 1ns/1ns

module bfly_mem_bank (
    input  logic               clk,
    input  logic               i_reset,
    input  bfly_pkg::req_pkt_t i_req_a,
    input  bfly_pkg::req_pkt_t i_req_b,
    input  logic               i_valid_a,
    input  logic               i_valid_b,
    output bfly_pkg::rsp_pkt_t o_rsp_a,
    output bfly_pkg::rsp_pkt_t o_rsp_b,
    output logic               o_valid_a,
    output logic               o_valid_b
);
    import bfly_pkg::*;

    localparam int DEPTH = 1 << LOCAL_ADDR_W;

    data_t       mem [DEPTH] = '{default: INIT_WORD};
    local_addr_t addr_a;
    local_addr_t addr_b;
    data_t       wdata_a;
    data_t       wdata_b;
    logic        we_a;
    logic        we_b;

    // Writes echo their own data, reads return the word before this edge
    function automatic rsp_pkt_t make_rsp(req_pkt_t req, data_t stored);
        rsp_pkt_t rsp;
        rsp = '0;
        rsp[RSP_RW_BIT] = req[REQ_RW_BIT];
        rsp[RSP_CORE_ID_LSB +: CORE_ID_W] = req[REQ_CORE_ID_LSB +: CORE_ID_W];
        rsp[RSP_DATA_LSB +: DATA_W] = req[REQ_RW_BIT] ? req[REQ_DATA_LSB +: DATA_W] : stored;
        return rsp;
    endfunction

    assign addr_a  = i_req_a[REQ_ADDR_LSB +: LOCAL_ADDR_W];
    assign addr_b  = i_req_b[REQ_ADDR_LSB +: LOCAL_ADDR_W];
    assign wdata_a = i_req_a[REQ_DATA_LSB +: DATA_W];
    assign wdata_b = i_req_b[REQ_DATA_LSB +: DATA_W];
    assign we_a    = i_valid_a && i_req_a[REQ_RW_BIT];
    assign we_b    = i_valid_b && i_req_b[REQ_RW_BIT];

    // Port A goes last so it keeps a same-address write
    always_ff @(posedge clk) begin
        if (we_b) begin
            mem[addr_b] <= wdata_b;
        end
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
    end

    always_ff @(posedge clk) begin
        o_rsp_a <= make_rsp(i_req_a, mem[addr_a]);
        o_rsp_b <= make_rsp(i_req_b, mem[addr_b]);
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid_a <= 1'b0;
            o_valid_b <= 1'b0;
        end else begin
            o_valid_a <= i_valid_a;
            o_valid_b <= i_valid_b;
        end
    end

    // Every accepted request is answered on the next cycle, on its own port
    a_one_cycle_latency: assert property (
        @(posedge clk) disable iff (i_reset)
        !$past(i_reset) |-> ({o_valid_a, o_valid_b} == $past({i_valid_a, i_valid_b}))
    );

endmodule

// ==== src/bfly_event_tally.sv ====
`timescale 1ns/1ns

module bfly_event_tally (
    input  logic                                                 clk,
    input  logic                                                 i_reset,
    input  logic [bfly_pkg::TOTAL_SWITCHES-1:0]                  i_collisions,
    input  logic [bfly_pkg::NUM_LAYERS-1:0][bfly_pkg::NUM_CORES-1:0] i_dropped_cores,
    output logic [bfly_pkg::NUM_CORES-1:0]                       o_dropped_cores,
    output bfly_pkg::coll_count_t                                o_total_collisions
);
    import bfly_pkg::*;

    coll_count_t          coll_sum;
    logic [NUM_CORES-1:0] drop_any;

    always_comb begin
        coll_sum = '0;
        drop_any = '0;
        for (int s = 0; s < TOTAL_SWITCHES; s++) begin
            coll_sum = coll_sum + coll_count_t'(i_collisions[s]);
        end
        // Explicit OR across all layers
        for (int l = 0; l < NUM_LAYERS; l++) begin
            drop_any = drop_any | i_dropped_cores[l];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_dropped_cores    <= '0;
            o_total_collisions <= '0;
        end else begin
            o_dropped_cores    <= drop_any;
            o_total_collisions <= coll_sum;
        end
    end

    // A reported drop must come from a collision somewhere in the network
    a_drop_has_collision: assert property (
        @(posedge clk) disable iff (i_reset)
        (|o_dropped_cores) |-> (o_total_collisions != '0)
    );

endmodule

// ==== src/bfly_memory_network.sv ====
`timescale 1ns/1ns

module bfly_memory_network (
    input  logic                                         clk,
    input  logic                                         i_reset,
    input  bfly_pkg::req_pkt_t [bfly_pkg::NUM_CORES-1:0] i_req,
    input  logic [bfly_pkg::NUM_CORES-1:0]               i_req_valid,
    output bfly_pkg::rsp_pkt_t [bfly_pkg::NUM_CORES-1:0] o_rsp,
    output logic [bfly_pkg::NUM_CORES-1:0]               o_rsp_valid,
    output logic [bfly_pkg::NUM_CORES-1:0]               o_dropped_cores,
    output bfly_pkg::coll_count_t                        o_total_collisions
);
    import bfly_pkg::*;

    localparam int SW_PER_LAYER = NUM_CORES / 2;

    // Index 0 is the layer input, the last index feeds the banks
    req_pkt_t [NUM_CORES-1:0] fwd_pkts  [NUM_FWD_LAYERS+1];
    logic [NUM_CORES-1:0]     fwd_valid [NUM_FWD_LAYERS+1];

    // Index 0 holds the bank responses, the last index goes to the cores
    rsp_pkt_t [NUM_CORES-1:0] bwd_pkts  [NUM_STAGES+1];
    logic [NUM_CORES-1:0]     bwd_valid [NUM_STAGES+1];

    logic [TOTAL_SWITCHES-1:0]              collisions;
    logic [NUM_LAYERS-1:0][NUM_CORES-1:0]   layer_drops;

    assign fwd_pkts[0]  = i_req;
    assign fwd_valid[0] = i_req_valid;

    // Forward layers route on the bank bits of mod_id
    for (genvar s = 0; s < NUM_FWD_LAYERS; s++) begin : g_fwd
        bfly_stage #(
            .PKT_W       (REQ_PKT_W),
            .ROUTE_LSB   (REQ_MOD_ID_LSB),
            .STAGE_IDX   (s),
            .OUT_PERMUTE (1'b1)
        ) u_stage (
            .clk             (clk),
            .i_reset         (i_reset),
            .i_pkts          (fwd_pkts[s]),
            .i_valid         (fwd_valid[s]),
            .o_pkts          (fwd_pkts[s+1]),
            .o_valid         (fwd_valid[s+1]),
            .o_collisions    (collisions[s*SW_PER_LAYER +: SW_PER_LAYER]),
            .o_dropped_cores (layer_drops[s])
        );
    end

    // Network port k lands on bank k/2, even ports on A and odd on B
    for (genvar p = 0; p < NUM_BANKS; p++) begin : g_bank
        bfly_mem_bank u_bank (
            .clk       (clk),
            .i_reset   (i_reset),
            .i_req_a   (fwd_pkts[NUM_FWD_LAYERS][2*p]),
            .i_req_b   (fwd_pkts[NUM_FWD_LAYERS][2*p+1]),
            .i_valid_a (fwd_valid[NUM_FWD_LAYERS][2*p]),
            .i_valid_b (fwd_valid[NUM_FWD_LAYERS][2*p+1]),
            .o_rsp_a   (bwd_pkts[0][2*p]),
            .o_rsp_b   (bwd_pkts[0][2*p+1]),
            .o_valid_a (bwd_valid[0][2*p]),
            .o_valid_b (bwd_valid[0][2*p+1])
        );
    end

    // Backward layers route on core_id, the last one leaves ports in place
    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_bwd
        localparam int LAYER = NUM_FWD_LAYERS + s;

        bfly_stage #(
            .PKT_W       (RSP_PKT_W),
            .ROUTE_LSB   (RSP_CORE_ID_LSB),
            .STAGE_IDX   (s),
            .OUT_PERMUTE (s != NUM_STAGES - 1)
        ) u_stage (
            .clk             (clk),
            .i_reset         (i_reset),
            .i_pkts          (bwd_pkts[s]),
            .i_valid         (bwd_valid[s]),
            .o_pkts          (bwd_pkts[s+1]),
            .o_valid         (bwd_valid[s+1]),
            .o_collisions    (collisions[LAYER*SW_PER_LAYER +: SW_PER_LAYER]),
            .o_dropped_cores (layer_drops[LAYER])
        );
    end

    assign o_rsp       = bwd_pkts[NUM_STAGES];
    assign o_rsp_valid = bwd_valid[NUM_STAGES];

    bfly_event_tally u_tally (
        .clk                (clk),
        .i_reset            (i_reset),
        .i_collisions       (collisions),
        .i_dropped_cores    (layer_drops),
        .o_dropped_cores    (o_dropped_cores),
        .o_total_collisions (o_total_collisions)
    );

endmodule

// ==== test/bfly_checker.sv ====
`timescale 1ns/1ns

module bfly_checker (
    input  logic                                         clk,
    input  logic                                         i_reset,
    input  logic                                         i_burst_mode,
    input  logic                                         i_done,
    input  logic [bfly_pkg::NUM_CORES-1:0]               i_exp_valid,
    input  bfly_pkg::rsp_pkt_t [bfly_pkg::NUM_CORES-1:0] i_exp_rsp,
    input  bfly_pkg::rsp_pkt_t [bfly_pkg::NUM_CORES-1:0] i_rsp,
    input  logic [bfly_pkg::NUM_CORES-1:0]               i_rsp_valid,
    input  logic [bfly_pkg::NUM_CORES-1:0]               i_dropped_cores,
    input  bfly_pkg::coll_count_t                        i_total_collisions,
    output int                                           o_error_count,
    output logic                                         o_report_done
);
    import bfly_pkg::*;

    // Request edge to response valid
    localparam int RSP_LATENCY = 6;
    // Last sampled cycle of a burst drain
    localparam int DRAIN_END   = 8;

    int                   cycle = 0;
    int                   value_errors = 0;
    int                   missing_errors = 0;
    int                   extra_errors = 0;
    int                   status_errors = 0;
    int                   rsp_checked = 0;
    int                   due_q [NUM_CORES][$];
    rsp_pkt_t             rsp_q [NUM_CORES][$];
    logic                 burst_active = 1'b0;
    int                   burst_start = 0;
    logic [NUM_CORES-1:0] burst_got = '0;
    logic [NUM_CORES-1:0] burst_drops = '0;
    int                   burst_colls = 0;
    logic                 report_done = 1'b0;

    assign o_error_count = value_errors + missing_errors + extra_errors + status_errors;
    assign o_report_done = report_done;

    task automatic record_expectations();
        if (i_burst_mode && (|i_exp_valid)) begin
            burst_active = 1'b1;
            burst_start  = cycle;
            burst_got    = '0;
            burst_drops  = '0;
            burst_colls  = 0;
        end
        for (int c = 0; c < NUM_CORES; c++) begin
            if (i_exp_valid[c]) begin
                due_q[c].push_back(cycle + RSP_LATENCY);
                rsp_q[c].push_back(i_exp_rsp[c]);
            end
        end
    endtask

    task automatic check_responses();
        for (int c = 0; c < NUM_CORES; c++) begin
            if (i_rsp_valid[c]) begin
                if (due_q[c].size() == 0 || due_q[c][0] != cycle) begin
                    extra_errors++;
                    $display("Unexpected response at core %0d at time %0t", c, $time);
                end else begin
                    if (i_rsp[c] !== rsp_q[c][0]) begin
                        value_errors++;
                        $display("FAILED %0t: core %0d response %h, expected %h",
                                 $time, c, i_rsp[c], rsp_q[c][0]);
                    end
                    rsp_checked++;
                    if (i_burst_mode) begin
                        burst_got[c] = 1'b1;
                    end
                    void'(due_q[c].pop_front());
                    void'(rsp_q[c].pop_front());
                end
            end else if (due_q[c].size() != 0 && due_q[c][0] == cycle) begin
                // In bursts a missing response is settled against the drop flags
                if (!i_burst_mode) begin
                    missing_errors++;
                    $display("No response at core %0d at time %0t", c, $time);
                end
                void'(due_q[c].pop_front());
                void'(rsp_q[c].pop_front());
            end
        end
    endtask

    task automatic evaluate_burst();
        for (int c = 0; c < NUM_CORES; c++) begin
            if (burst_got[c] && burst_drops[c]) begin
                status_errors++;
                $display("Core %0d was answered and also flagged as dropped at time %0t",
                         c, $time);
            end else if (!burst_got[c] && !burst_drops[c]) begin
                status_errors++;
                $display("Core %0d got no response and no drop flag at time %0t", c, $time);
            end
        end
        if (burst_colls != $countones(burst_drops)) begin
            status_errors++;
            $display("FAILED %0t: burst collision sum %0d, dropped cores %0d",
                     $time, burst_colls, $countones(burst_drops));
        end
    endtask

    task automatic check_status();
        if (!i_burst_mode) begin
            if (i_dropped_cores !== '0 || i_total_collisions !== '0) begin
                status_errors++;
                $display("FAILED %0t: drop flags %b, collision count %0d, expected zero",
                         $time, i_dropped_cores, i_total_collisions);
            end
        end else if (burst_active) begin
            burst_drops = burst_drops | i_dropped_cores;
            burst_colls = burst_colls + int'(i_total_collisions);
            if (cycle == burst_start + DRAIN_END) begin
                evaluate_burst();
                burst_active = 1'b0;
            end
        end
    endtask

    task automatic final_report();
        for (int c = 0; c < NUM_CORES; c++) begin
            if (due_q[c].size() != 0) begin
                missing_errors += due_q[c].size();
                $display("Responses still pending at core %0d at the end", c);
            end
        end
        if (rsp_checked == 0) begin
            status_errors++;
            $display("No response was checked during the run");
        end
        $display("Check summary: %0d responses, %0d value, %0d missing, %0d extra, %0d status",
                 rsp_checked, value_errors, missing_errors, extra_errors, status_errors);
        report_done = 1'b1;
    endtask

    // Sample away from the rising edge where the DUT and the stimulus change
    always @(negedge clk) begin
        if (!i_reset) begin
            cycle++;
            record_expectations();
            check_responses();
            check_status();
            if (i_done && !report_done) begin
                final_report();
            end
        end
    end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;
    import bfly_pkg::*;

    localparam int          CLK_HALF   = 20;
    localparam int          CLK_PERIOD = 2 * CLK_HALF;
    localparam int          P1_COUNT   = 160;
    localparam int          P2_BURSTS  = 16;
    // One injection cycle and eight idle cycles
    localparam int          BURST_LEN  = 9;
    localparam logic [31:0] SEED       = 32'h17c5_7122;
    localparam int          NUM_WORDS  = 1 << LOCAL_ADDR_W;

    logic                     clk = 1'b0;
    logic                     reset;
    req_pkt_t [NUM_CORES-1:0] req;
    logic [NUM_CORES-1:0]     req_valid;
    rsp_pkt_t [NUM_CORES-1:0] rsp;
    logic [NUM_CORES-1:0]     rsp_valid;
    logic [NUM_CORES-1:0]     dropped_cores;
    coll_count_t              total_collisions;
    logic [NUM_CORES-1:0]     exp_valid;
    rsp_pkt_t [NUM_CORES-1:0] exp_rsp;
    logic                     burst_mode;
    logic                     done;
    int                       error_count;
    logic                     report_done;
    data_t                    model_mem [NUM_BANKS][NUM_WORDS];

    always #CLK_HALF clk = ~clk;

    bfly_memory_network uut (
        .clk                (clk),
        .i_reset            (reset),
        .i_req              (req),
        .i_req_valid        (req_valid),
        .o_rsp              (rsp),
        .o_rsp_valid        (rsp_valid),
        .o_dropped_cores    (dropped_cores),
        .o_total_collisions (total_collisions)
    );

    bfly_checker u_checker (
        .clk                (clk),
        .i_reset            (reset),
        .i_burst_mode       (burst_mode),
        .i_done             (done),
        .i_exp_valid        (exp_valid),
        .i_exp_rsp          (exp_rsp),
        .i_rsp              (rsp),
        .i_rsp_valid        (rsp_valid),
        .i_dropped_cores    (dropped_cores),
        .i_total_collisions (total_collisions),
        .o_error_count      (error_count),
        .o_report_done      (report_done)
    );

    // Random request for one core, the model gives the response it must get
    task automatic make_request(input int core, input logic rw,
                                output req_pkt_t pkt, output rsp_pkt_t want);
        logic [31:0]           rnd;
        logic [31:0]           data_rnd;
        logic [MOD_ID_W-2:0]   bank;
        logic                  port;
        local_addr_t           addr;
        prio_t                 prio;
        data_t                 data;
        data_t                 result;
        rnd      = $urandom;
        data_rnd = $urandom;
        bank     = rnd[8 +: MOD_ID_W-1];
        addr     = rnd[16 +: LOCAL_ADDR_W];
        prio     = rnd[24 +: PRIO_W];
        port     = rnd[31];
        data     = data_rnd[DATA_W-1:0];
        if (rw) begin
            model_mem[bank][addr] = data;
            result = data;
        end else begin
            result = model_mem[bank][addr];
        end
        pkt  = {rw, core_id_t'(core), bank, port, addr, prio, data};
        want = {rw, core_id_t'(core), result};
    endtask

    initial begin
        int                       core;
        logic [31:0]              rnd;
        req_pkt_t                 pkt;
        rsp_pkt_t                 want;
        logic [NUM_CORES-1:0]     one_hot;
        req_pkt_t [NUM_CORES-1:0] burst_req;
        rsp_pkt_t [NUM_CORES-1:0] burst_want;

        void'($urandom(SEED));
        reset      = 1'b1;
        req        = '0;
        req_valid  = '0;
        exp_valid  = '0;
        exp_rsp    = '0;
        burst_mode = 1'b0;
        done       = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < NUM_WORDS; w++) begin
                model_mem[b][w] = '1;
            end
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);

        // Phase 1, one core per cycle
        for (int n = 0; n < P1_COUNT; n++) begin
            rnd  = $urandom;
            core = rnd % NUM_CORES;
            make_request(core, rnd[3], pkt, want);
            one_hot       = '0;
            one_hot[core] = 1'b1;
            @(posedge clk);
            req[core]     <= pkt;
            req_valid     <= one_hot;
            exp_rsp[core] <= want;
            exp_valid     <= one_hot;
        end
        @(posedge clk);
        req_valid <= '0;
        exp_valid <= '0;
        repeat (10) @(posedge clk);

        // Phase 2, all cores read in the same cycle
        for (int b = 0; b < P2_BURSTS; b++) begin
            for (int c = 0; c < NUM_CORES; c++) begin
                make_request(c, 1'b0, burst_req[c], burst_want[c]);
            end
            @(posedge clk);
            burst_mode <= 1'b1;
            req        <= burst_req;
            req_valid  <= '1;
            exp_rsp    <= burst_want;
            exp_valid  <= '1;
            @(posedge clk);
            req_valid <= '0;
            exp_valid <= '0;
            repeat (BURST_LEN - 2) @(posedge clk);
        end

        @(posedge clk);
        done <= 1'b1;
        while (!report_done) @(posedge clk);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the phase lengths plus margin for reset and drain
    initial begin
        #((P1_COUNT + P2_BURSTS * BURST_LEN + 50) * CLK_PERIOD);
        $display("Timeout: the run did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== tb.f ====
src/bfly_pkg.sv
src/bfly_switch.sv
src/bfly_stage.sv
src/bfly_mem_bank.sv
src/bfly_event_tally.sv
src/bfly_memory_network.sv
test/bfly_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }

grep -q "Regression failed" sim.log \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }
